/* logic/aes_pkg.sv */
package aes_pkg;

  // cipher widths, fixed by the standard
  typedef logic [127:0] aes_block_t;
  typedef logic [31:0] aes_word_t;
  typedef logic [7:0] aes_byte_t;
  typedef logic [7:0] aes_rcon_t;

  // aes-128 round count
  localparam int aes_rounds = 10;

  // multiply by x in gf(2^8), poly 0x11b
  function automatic aes_byte_t xtime(input aes_byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // shift-and-add multiply
  function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
    aes_byte_t acc;
    aes_byte_t p;
    acc = '0;
    p = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ p;
      end
      p = xtime(p);
    end
    return acc;
  endfunction

  // a^254 as product of a^2 .. a^128, zero maps to zero
  function automatic aes_byte_t gf_inv(input aes_byte_t a);
    aes_byte_t r;
    aes_byte_t p;
    r = 8'h01;
    p = a;
    for (int k = 1; k < 8; k++) begin
      p = gf_mul(p, p);
      r = gf_mul(r, p);
    end
    return r;
  endfunction

  function automatic aes_byte_t rotl8(input aes_byte_t b, input int n);
    return (b << n) | (b >> (8 - n));
  endfunction

  // inverse, then affine map
  function automatic aes_byte_t sbox(input aes_byte_t b);
    aes_byte_t v;
    v = gf_inv(b);
    return v ^ rotl8(v, 1) ^ rotl8(v, 2) ^ rotl8(v, 3) ^ rotl8(v, 4) ^ 8'h63;
  endfunction

  // inverse affine map, then inverse
  function automatic aes_byte_t inv_sbox(input aes_byte_t b);
    return gf_inv(rotl8(b, 1) ^ rotl8(b, 3) ^ rotl8(b, 6) ^ 8'h05);
  endfunction

  // column is {a0, a1, a2, a3}, a0 in the top byte
  function automatic aes_word_t mix_column(input aes_word_t col);
    aes_byte_t a0, a1, a2, a3;
    {a0, a1, a2, a3} = col;
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  // coefficients 0e 0b 0d 09
  function automatic aes_word_t inv_mix_column(input aes_word_t col);
    aes_byte_t a0, a1, a2, a3;
    {a0, a1, a2, a3} = col;
    return {gf_mul(a0, 8'h0e) ^ gf_mul(a1, 8'h0b) ^ gf_mul(a2, 8'h0d) ^ gf_mul(a3, 8'h09),
            gf_mul(a0, 8'h09) ^ gf_mul(a1, 8'h0e) ^ gf_mul(a2, 8'h0b) ^ gf_mul(a3, 8'h0d),
            gf_mul(a0, 8'h0d) ^ gf_mul(a1, 8'h09) ^ gf_mul(a2, 8'h0e) ^ gf_mul(a3, 8'h0b),
            gf_mul(a0, 8'h0b) ^ gf_mul(a1, 8'h0d) ^ gf_mul(a2, 8'h09) ^ gf_mul(a3, 8'h0e)};
  endfunction

endpackage

/* logic/mmio_pkg.sv */
package mmio_pkg;

  // word index inside the operand area
  typedef logic [3:0] word_idx_t;

  // region value in address bits 19:16
  localparam logic [3:0] aes_region = 4'h4;

  // control register, full 20-bit match
  localparam logic [19:0] aes_ctrl_addr = 20'h4_1000;

  // control register bit positions
  localparam int ctrl_encrypt_bit = 0;
  localparam int ctrl_decrypt_bit = 1;
  localparam int ctrl_valid_bit = 2;

  // memory layout, big-endian words
  // key in words 0..3
  localparam word_idx_t key_base = 4'd0;
  // input block in words 4..7
  localparam word_idx_t in_base = 4'd4;
  // result in words 8..11
  localparam word_idx_t out_base = 4'd8;

endpackage

/* logic/aes_mem.sv */
module aes_mem import aes_pkg::*; #(
  parameter int mem_addr_width = 10
) (
  input  logic                      clk_in,
  // cpu port, byte lanes
  input  logic [mem_addr_width-1:0] cpu_addr,
  input  logic [3:0]                cpu_we,
  input  aes_word_t                 cpu_wdata,
  output aes_word_t                 cpu_rdata,
  // engine port, whole words
  input  logic [mem_addr_width-1:0] aes_addr,
  input  logic                      aes_we,
  input  aes_word_t                 aes_wdata,
  output aes_word_t                 aes_rdata
);

  aes_word_t mem [2**mem_addr_width];

  always_ff @(posedge clk_in) begin
    // cpu lanes first
    for (int i = 0; i < 4; i++) begin
      if (cpu_we[i]) begin
        mem[cpu_addr][8*i +: 8] <= cpu_wdata[8*i +: 8];
      end
    end
    // engine write last so it wins a collision
    if (aes_we) begin
      mem[aes_addr] <= aes_wdata;
    end
    // registered reads, old data on same-cycle write
    cpu_rdata <= mem[cpu_addr];
    aes_rdata <= mem[aes_addr];
  end

endmodule

/* logic/aes_key_sched.sv */
module aes_key_sched import aes_pkg::*; (
  input  aes_block_t key,
  input  aes_rcon_t  rcon,
  input  logic       inverse,
  output aes_block_t next_key
);

  aes_word_t w0, w1, w2, w3;
  // previous word 3, only meaningful in inverse mode
  aes_word_t prev_w3;
  aes_word_t sub_in;
  aes_word_t rot;
  aes_word_t temp;

  always_comb begin
    {w0, w1, w2, w3} = key;
    prev_w3 = w3 ^ w2;
    // g() always works on the old round key's last word
    sub_in = inverse ? prev_w3 : w3;
    // rotword
    rot = {sub_in[23:0], sub_in[31:24]};
    // subword plus rcon on the top byte
    temp = {sbox(rot[31:24]), sbox(rot[23:16]), sbox(rot[15:8]), sbox(rot[7:0])}
           ^ {rcon, 24'h0};
    if (inverse) begin
      // undo the xor chain, then recover word 0
      next_key = {w0 ^ temp, w1 ^ w0, w2 ^ w1, prev_w3};
    end else begin
      next_key[127:96] = w0 ^ temp;
      next_key[95:64] = w1 ^ next_key[127:96];
      next_key[63:32] = w2 ^ next_key[95:64];
      next_key[31:0] = w3 ^ next_key[63:32];
    end
  end

endmodule

/* logic/aes_round.sv */
module aes_round import aes_pkg::*; (
  input  aes_block_t state,
  input  aes_block_t round_key,
  input  logic       decrypt,
  input  logic       last,
  output aes_block_t next_state
);

  // byte i of the standard sits at bits 127-8i
  aes_byte_t  in_b [16];
  // subbytes+shiftrows / invshiftrows+invsubbytes
  aes_block_t enc_s;
  aes_block_t dec_s;
  aes_block_t enc_m;
  aes_block_t dec_k;
  aes_block_t dec_m;
  aes_block_t enc_out;
  aes_block_t dec_out;

  always_comb begin
    for (int i = 0; i < 16; i++) begin
      in_b[i] = state[127-8*i -: 8];
    end
    // row r of column c is byte r+4c
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        // row r moves left by r columns
        enc_s[127-8*(r+4*c) -: 8] = sbox(in_b[r + 4*((c + r) % 4)]);
        // and back right on decrypt
        dec_s[127-8*(r+4*c) -: 8] = inv_sbox(in_b[r + 4*((c + 4 - r) % 4)]);
      end
    end
    dec_k = dec_s ^ round_key;
    for (int c = 0; c < 4; c++) begin
      enc_m[127-32*c -: 32] = mix_column(enc_s[127-32*c -: 32]);
      dec_m[127-32*c -: 32] = inv_mix_column(dec_k[127-32*c -: 32]);
    end
    // last round has no column mixing
    enc_out = (last ? enc_s : enc_m) ^ round_key;
    dec_out = last ? dec_k : dec_m;
    next_state = decrypt ? dec_out : enc_out;
  end

endmodule

/* logic/aes_engine.sv */
module aes_engine import aes_pkg::*, mmio_pkg::*; #(
  parameter int mem_addr_width = 10
) (
  input  logic                      clk_in,
  input  logic                      arst_n,
  // command from control register
  input  logic                      start,
  input  logic                      decrypt,
  output logic                      busy,
  output logic                      done,
  // engine port of the shared memory
  output logic [mem_addr_width-1:0] aes_addr,
  output logic                      aes_we,
  output aes_word_t                 aes_wdata,
  input  aes_word_t                 aes_rdata
);

  typedef enum logic [2:0] {
    st_idle,
    st_load,
    st_expand,
    st_init_xor,
    st_rounds,
    st_store
  } engine_state_t;

  engine_state_t fsm_q;
  logic [3:0]    cnt_q;
  logic          dec_q;

  // datapath
  aes_block_t key_q;
  aes_block_t blk_q;
  aes_rcon_t  rcon_q;
  aes_block_t round_out;
  aes_block_t key_next;
  logic       key_inverse;
  logic       last_round;
  word_idx_t  word_idx;

  // undo xtime, odd values had the 0x1b folded in
  function automatic aes_rcon_t inv_xtime(input aes_rcon_t r);
    return r[0] ? (((r ^ 8'h1b) >> 1) | 8'h80) : (r >> 1);
  endfunction

  // expand always walks forward, even for decrypt
  assign key_inverse = dec_q && (fsm_q != st_expand);
  assign last_round = (cnt_q == 4'(aes_rounds - 1));
  assign busy = (fsm_q != st_idle);

  aes_round u_round (
    .state      (blk_q),
    .round_key  (key_q),
    .decrypt    (dec_q),
    .last       (last_round),
    .next_state (round_out)
  );

  aes_key_sched u_key_sched (
    .key      (key_q),
    .rcon     (rcon_q),
    .inverse  (key_inverse),
    .next_key (key_next)
  );

  // memory port and done, decoded from state
  always_comb begin
    word_idx = key_base;
    aes_we = 1'b0;
    done = 1'b0;
    case (fsm_q)
      // idle presents word 0 so the first load cycle has data
      st_idle: word_idx = key_base;
      // read one word ahead
      st_load: word_idx = key_base + cnt_q + 4'd1;
      st_store: begin
        word_idx = out_base + cnt_q;
        aes_we = 1'b1;
        done = (cnt_q == 4'd3);
      end
      default: word_idx = key_base;
    endcase
    aes_addr = mem_addr_width'(word_idx);
    // result leaves from the top of the block register
    aes_wdata = blk_q[127:96];
  end

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      fsm_q <= st_idle;
      cnt_q <= '0;
      dec_q <= 1'b0;
    end else begin
      case (fsm_q)
        st_idle: begin
          cnt_q <= '0;
          if (start) begin
            dec_q <= decrypt;
            fsm_q <= st_load;
          end
        end
        st_load: begin
          cnt_q <= cnt_q + 4'd1;
          // eight words, key then block
          if (cnt_q == 4'd7) begin
            cnt_q <= '0;
            fsm_q <= dec_q ? st_expand : st_init_xor;
          end
        end
        st_expand: begin
          cnt_q <= cnt_q + 4'd1;
          if (cnt_q == 4'(aes_rounds - 1)) begin
            cnt_q <= '0;
            fsm_q <= st_init_xor;
          end
        end
        st_init_xor: begin
          cnt_q <= '0;
          fsm_q <= st_rounds;
        end
        st_rounds: begin
          cnt_q <= cnt_q + 4'd1;
          if (last_round) begin
            cnt_q <= '0;
            fsm_q <= st_store;
          end
        end
        st_store: begin
          cnt_q <= cnt_q + 4'd1;
          if (cnt_q == 4'd3) begin
            cnt_q <= '0;
            fsm_q <= st_idle;
          end
        end
        default: fsm_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    case (fsm_q)
      st_idle: rcon_q <= 8'h01;
      st_load: begin
        // words below in_base are key
        if (cnt_q < in_base) begin
          key_q <= {key_q[95:0], aes_rdata};
        end else begin
          blk_q <= {blk_q[95:0], aes_rdata};
        end
      end
      st_expand: begin
        key_q <= key_next;
        // hold 0x36 after the last step, it undoes round key 10
        if (cnt_q != 4'(aes_rounds - 1)) begin
          rcon_q <= xtime(rcon_q);
        end
      end
      st_init_xor, st_rounds: begin
        if (fsm_q == st_init_xor) begin
          blk_q <= blk_q ^ key_q;
        end else begin
          blk_q <= round_out;
        end
        // round key for the next cycle
        key_q <= key_next;
        rcon_q <= dec_q ? inv_xtime(rcon_q) : xtime(rcon_q);
      end
      st_store: blk_q <= {blk_q[95:0], 32'h0};
      default: rcon_q <= 8'h01;
    endcase
  end

endmodule

/* logic/aes_coprocessor.sv */
module aes_coprocessor import aes_pkg::*, mmio_pkg::*; #(
  parameter int mem_addr_width = 10
) (
  input  logic       clk_in,
  input  logic       arst_n,
  // cpu bus
  input  aes_word_t  cpu_addr_in,
  input  aes_word_t  cpu_data_in,
  input  logic [3:0] cpu_write_enable_in,
  output aes_word_t  cpu_data_out
);

  // address decode
  logic       in_region;
  logic       is_ctrl;
  logic [3:0] mem_we;
  logic       ctrl_we;

  // control register {valid, decrypt, encrypt}
  logic [2:0] ctrl_q;

  // engine handshake
  logic start;
  logic busy;
  logic done;

  // engine memory port
  logic [mem_addr_width-1:0] aes_addr;
  logic                      aes_we;
  aes_word_t                 aes_wdata;
  aes_word_t                 aes_rdata;

  // read path, select lines up with the memory's registered read
  aes_word_t mem_rdata;
  logic      rd_mem_q;
  logic      rd_ctrl_q;

  assign in_region = (cpu_addr_in[19:16] == aes_region);
  assign is_ctrl = (cpu_addr_in[19:0] == aes_ctrl_addr);
  // control address is not backed by memory
  assign mem_we = (in_region && !is_ctrl) ? cpu_write_enable_in : 4'h0;
  // ctrl bits live in lane 0
  assign ctrl_we = is_ctrl && cpu_write_enable_in[0];

  // fires once, engine goes busy on the next edge
  assign start = !busy && (ctrl_q[ctrl_encrypt_bit] || ctrl_q[ctrl_decrypt_bit]);

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_q <= '0;
    end else if (done) begin
      // completion beats a same-cycle cpu write
      ctrl_q[ctrl_valid_bit] <= 1'b1;
      ctrl_q[ctrl_decrypt_bit] <= 1'b0;
      ctrl_q[ctrl_encrypt_bit] <= 1'b0;
    end else if (ctrl_we) begin
      ctrl_q <= cpu_data_in[2:0];
    end
  end

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      rd_mem_q <= 1'b0;
      rd_ctrl_q <= 1'b0;
    end else begin
      rd_mem_q <= in_region && !is_ctrl;
      rd_ctrl_q <= is_ctrl;
    end
  end

  // zero outside the region
  always_comb begin
    if (rd_ctrl_q) begin
      cpu_data_out = aes_word_t'(ctrl_q);
    end else if (rd_mem_q) begin
      cpu_data_out = mem_rdata;
    end else begin
      cpu_data_out = '0;
    end
  end

  aes_engine #(
    .mem_addr_width (mem_addr_width)
  ) u_engine (
    .clk_in    (clk_in),
    .arst_n    (arst_n),
    .start     (start),
    .decrypt   (ctrl_q[ctrl_decrypt_bit]),
    .busy      (busy),
    .done      (done),
    .aes_addr  (aes_addr),
    .aes_we    (aes_we),
    .aes_wdata (aes_wdata),
    .aes_rdata (aes_rdata)
  );

  // word index from address bits 2 and up
  aes_mem #(
    .mem_addr_width (mem_addr_width)
  ) u_mem (
    .clk_in    (clk_in),
    .cpu_addr  (cpu_addr_in[mem_addr_width+1:2]),
    .cpu_we    (mem_we),
    .cpu_wdata (cpu_data_in),
    .cpu_rdata (mem_rdata),
    .aes_addr  (aes_addr),
    .aes_we    (aes_we),
    .aes_wdata (aes_wdata),
    .aes_rdata (aes_rdata)
  );

endmodule

/* verification/aes_coprocessor_properties.sv */
module aes_coprocessor_properties import mmio_pkg::*; #(
  parameter int mem_addr_width = 10
) (
  input logic                      clk_in,
  input logic                      arst_n,
  input logic [2:0]                ctrl_q,
  input logic                      start,
  input logic                      busy,
  input logic                      done,
  input logic                      aes_we,
  input logic [mem_addr_width-1:0] aes_addr
);

  timeunit 1ns;
  timeprecision 1ps;

  // failures seen so far, read by the testbench at the end
  int assert_errors = 0;

  // everything quiet while reset is held
  reset_quiet: assert property (@(posedge clk_in)
    !arst_n |-> (ctrl_q == 3'b000 && !start && !busy && !done))
    else begin
      $error("control or engine output set during reset");
      assert_errors++;
    end

  // worst case is a decrypt, 33 cycles
  start_to_done: assert property (@(posedge clk_in) disable iff (!arst_n)
    start |-> ##[1:40] done)
    else begin
      $error("start not followed by done within 40 cycles");
      assert_errors++;
    end

  // done leaves valid only
  done_sets_valid: assert property (@(posedge clk_in) disable iff (!arst_n)
    done |=> (ctrl_q[ctrl_valid_bit] && !ctrl_q[ctrl_encrypt_bit] && !ctrl_q[ctrl_decrypt_bit]))
    else begin
      $error("valid not set or command bits not cleared after done");
      assert_errors++;
    end

  valid_needs_done: assert property (@(posedge clk_in) disable iff (!arst_n)
    $rose(ctrl_q[ctrl_valid_bit]) |-> $past(done))
    else begin
      $error("valid rose without done");
      assert_errors++;
    end

  // engine stores only into the result words
  store_window: assert property (@(posedge clk_in) disable iff (!arst_n)
    aes_we |-> (aes_addr >= out_base && aes_addr < out_base + 4))
    else begin
      $error("engine write outside the result words");
      assert_errors++;
    end

  // a running engine always has its command pending
  busy_has_cmd: assert property (@(posedge clk_in) disable iff (!arst_n)
    busy |-> (ctrl_q[ctrl_encrypt_bit] || ctrl_q[ctrl_decrypt_bit]))
    else begin
      $error("engine busy while the control register is idle");
      assert_errors++;
    end

endmodule

bind aes_coprocessor aes_coprocessor_properties #(
  .mem_addr_width (mem_addr_width)
) props (
  .clk_in   (clk_in),
  .arst_n   (arst_n),
  .ctrl_q   (ctrl_q),
  .start    (start),
  .busy     (busy),
  .done     (done),
  .aes_we   (aes_we),
  .aes_addr (aes_addr)
);

/* verification/aes_coprocessor_tb.sv */
module aes_coprocessor_tb import aes_pkg::*, mmio_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // fips-197 appendix c.1
  localparam aes_block_t fips_key = 128'h000102030405060708090a0b0c0d0e0f;
  localparam aes_block_t fips_pt = 128'h00112233445566778899aabbccddeeff;
  localparam aes_block_t fips_ct = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam aes_word_t ctrl_addr = {12'h000, aes_ctrl_addr};
  // region 5, outside the window
  localparam aes_word_t outside_base = 32'h0005_0000;

  logic       clk_in = 1'b0;
  logic       arst_n;
  aes_word_t  cpu_addr_in;
  aes_word_t  cpu_data_in;
  logic [3:0] cpu_write_enable_in;
  aes_word_t  cpu_data_out;

  int errors = 0;
  int timeouts = 0;

  aes_coprocessor #(
    .mem_addr_width (10)
  ) uut (
    .clk_in              (clk_in),
    .arst_n              (arst_n),
    .cpu_addr_in         (cpu_addr_in),
    .cpu_data_in         (cpu_data_in),
    .cpu_write_enable_in (cpu_write_enable_in),
    .cpu_data_out        (cpu_data_out)
  );

  always #5 clk_in = ~clk_in;

  function automatic aes_word_t word_addr(input int w);
    return {12'h000, aes_region, 16'h0000} | aes_word_t'(w << 2);
  endfunction

  // write lands on the following edge
  task automatic write_word(input aes_word_t addr, input aes_word_t data, input logic [3:0] be);
    @(posedge clk_in);
    #1;
    cpu_addr_in = addr;
    cpu_data_in = data;
    cpu_write_enable_in = be;
    @(posedge clk_in);
    #1;
    cpu_write_enable_in = 4'h0;
  endtask

  // registered read, one cycle behind the address
  task automatic read_word(input aes_word_t addr, output aes_word_t data);
    @(posedge clk_in);
    #1;
    cpu_addr_in = addr;
    cpu_write_enable_in = 4'h0;
    @(posedge clk_in);
    #1;
    data = cpu_data_out;
  endtask

  // word n takes bytes 4n..4n+3, big-endian
  task automatic write_block(input int base, input aes_block_t blk);
    for (int i = 0; i < 4; i++) begin
      write_word(word_addr(base + i), blk[127-32*i -: 32], 4'hf);
    end
  endtask

  task automatic read_block(input int base, output aes_block_t blk);
    aes_word_t w;
    for (int i = 0; i < 4; i++) begin
      read_word(word_addr(base + i), w);
      blk[127-32*i -: 32] = w;
    end
  endtask

  task automatic check_value(input string name, input logic [127:0] exp, input logic [127:0] act);
    assert (act === exp)
      else begin
        $display("Error at %0t ns: %s expected %0h actual %0h", $time, name, exp, act);
        errors++;
      end
  endtask

  // poll valid, 100 cycles at most
  task automatic wait_valid(input string what);
    aes_word_t r;
    int cycles;
    r = '0;
    cycles = 0;
    while (!r[ctrl_valid_bit] && cycles < 100) begin
      read_word(ctrl_addr, r);
      cycles += 2;
    end
    if (!r[ctrl_valid_bit]) begin
      $display("timeout: valid bit never came up after %s", what);
      timeouts++;
    end
  endtask

  // command write clears valid, then wait for it again
  task automatic issue_cmd(input int bit_pos, input string what);
    aes_word_t r;
    write_word(ctrl_addr, aes_word_t'(1 << bit_pos), 4'h1);
    wait_valid(what);
    read_word(ctrl_addr, r);
    check_value({what, " ctrl"}, 32'h4, r);
  endtask

  initial begin
    aes_word_t  r;
    aes_word_t  old_w;
    aes_word_t  new_w;
    aes_word_t  exp_w;
    logic [3:0] lanes;
    aes_block_t key;
    aes_block_t blk;
    aes_block_t res;

    void'($urandom(32'h75d6));
    arst_n = 1'b0;
    cpu_addr_in = '0;
    cpu_data_in = '0;
    cpu_write_enable_in = 4'h0;
    repeat (8) @(posedge clk_in);
    #1;
    arst_n = 1'b1;

    // reset values
    read_word(ctrl_addr, r);
    check_value("ctrl after reset", 32'h0, r);
    read_word(outside_base | 32'h10, r);
    check_value("outside read", 32'h0, r);

    // known answer, encrypt then decrypt
    write_block(key_base, fips_key);
    write_block(in_base, fips_pt);
    issue_cmd(ctrl_encrypt_bit, "fips encrypt");
    read_block(out_base, res);
    check_value("fips ciphertext", fips_ct, res);
    write_block(in_base, fips_ct);
    issue_cmd(ctrl_decrypt_bit, "fips decrypt");
    read_block(out_base, res);
    check_value("fips plaintext", fips_pt, res);

    // round trip on random operands
    for (int n = 0; n < 8; n++) begin
      key = {$urandom(), $urandom(), $urandom(), $urandom()};
      blk = {$urandom(), $urandom(), $urandom(), $urandom()};
      write_block(key_base, key);
      write_block(in_base, blk);
      issue_cmd(ctrl_encrypt_bit, "random encrypt");
      read_block(out_base, res);
      write_block(in_base, res);
      issue_cmd(ctrl_decrypt_bit, "random decrypt");
      read_block(out_base, res);
      check_value("round trip block", blk, res);
    end

    // byte lanes on word 20
    for (int n = 0; n < 4; n++) begin
      old_w = $urandom();
      new_w = $urandom();
      lanes = 4'($urandom());
      write_word(word_addr(20), old_w, 4'hf);
      write_word(word_addr(20), new_w, lanes);
      for (int i = 0; i < 4; i++) begin
        exp_w[8*i +: 8] = lanes[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
      end
      read_word(word_addr(20), r);
      check_value("byte lane word", exp_w, r);
    end
    // same index, other region
    write_word(outside_base | 32'h50, ~exp_w, 4'hf);
    read_word(word_addr(20), r);
    check_value("word after outside write", exp_w, r);

    // clear valid, then a fresh command
    write_word(ctrl_addr, 32'h0, 4'h1);
    read_word(ctrl_addr, r);
    check_value("ctrl after clear", 32'h0, r);
    issue_cmd(ctrl_encrypt_bit, "encrypt after clear");

    repeat (5) @(posedge clk_in);
    $display("check errors %0d, timeouts %0d, assertion errors %0d",
             errors, timeouts, uut.props.assert_errors);
    if (errors == 0 && timeouts == 0 && uut.props.assert_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* list.f */
logic/aes_pkg.sv
logic/mmio_pkg.sv
logic/aes_mem.sv
logic/aes_key_sched.sv
logic/aes_round.sv
logic/aes_engine.sv
logic/aes_coprocessor.sv
verification/aes_coprocessor_properties.sv
verification/aes_coprocessor_tb.sv

/* Bender.yml */
package:
  name: aes_coprocessor

sources:
  - target: any(rtl, test)
    files:
      - logic/aes_pkg.sv
      - logic/mmio_pkg.sv
      - logic/aes_mem.sv
      - logic/aes_key_sched.sv
      - logic/aes_round.sv
      - logic/aes_engine.sv
      - logic/aes_coprocessor.sv
  - target: test
    files:
      - verification/aes_coprocessor_properties.sv
      - verification/aes_coprocessor_tb.sv
